//--- Bender.yml
package:
  name: uart_apb

sources:
  # RTL
  - files:
      - uart_pkg.sv
      - uart_rx.sv
      - uart_tx.sv
      - uart_rx_fifo.sv
      - uart_apb_regs.sv
      - uart_apb_top.sv
  # Testbench
  - target: test
    files:
      - uart_checker.sv
      - uart_asserts.sv
      - tb_uart_apb.sv

//--- compile.f
uart_pkg.sv
uart_rx.sv
uart_tx.sv
uart_rx_fifo.sv
uart_apb_regs.sv
uart_apb_top.sv
uart_checker.sv
uart_asserts.sv
tb_uart_apb.sv

//--- tb_uart_apb.sv
`timescale 1ns/1ps
`default_nettype none

module tb_uart_apb;
    import uart_pkg::*;

    logic       clk;
    logic       rst;
    apb_addr_t  paddr;
    logic       psel;
    logic       penable;
    logic       pwrite;
    apb_word_t  pwdata;
    apb_word_t  prdata;
    logic       pready;
    logic       pslverr;
    logic       rx;
    logic       tx;

    logic       chk_en;        // Compare prdata in this access
    apb_word_t  chk_data;
    apb_word_t  chk_mask;      // Only these prdata bits are compared
    logic       exp_slverr;
    logic       tx_push;       // Hands one expected byte to the checker
    uart_byte_t tx_push_byte;
    int         chk_errors;
    int         tx_frames;     // Frames the checker has decoded on tx

    // Reference model of the receive side
    uart_byte_t exp_rx_q[$];
    logic       exp_overrun;
    logic       exp_frame_err;
    logic       exp_rx_en;
    int         tx_sent;       // Bytes the transmitter accepted
    int         tb_errors;
    int         seed;
    uart_byte_t b;
    int         n;
    int         i;
    int         j;

    uart_apb_top u_uart_apb_top (
        .clk, .rst, .paddr, .psel, .penable, .pwrite, .pwdata, .prdata, .pready, .pslverr,
        .rx, .tx
    );

    uart_checker u_checker (
        .clk, .rst, .paddr, .psel, .penable, .prdata, .pslverr, .tx, .chk_en, .chk_data,
        .chk_mask, .exp_slverr, .tx_push, .tx_push_byte, .errors(chk_errors), .frames(tx_frames)
    );

    always #5 clk = ~clk;

    // One APB transfer with setup on one falling edge and access on the next
    task automatic apb_xfer(input logic write, input apb_addr_t addr, input apb_word_t wdata,
                            input logic check, input apb_word_t want, input apb_word_t mask,
                            output apb_word_t data);
        @(negedge clk);
        paddr      = addr;
        pwrite     = write;
        pwdata     = wdata;
        psel       = 1'b1;
        penable    = 1'b0;
        chk_en     = check;
        chk_data   = want;
        chk_mask   = mask;
        exp_slverr = !(addr inside {addr_data, addr_status, addr_ctrl}); // Only three registers
        @(negedge clk);
        penable = 1'b1;
        @(posedge clk);    // Access edge since pready is always high
        data = prdata;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        chk_en  = 1'b0;
    endtask

    task automatic apb_write(input apb_addr_t addr, input apb_word_t wdata);
        apb_word_t discard;
        apb_xfer(1'b1, addr, wdata, 1'b0, '0, '0, discard);
    endtask

    task automatic read_check(input apb_addr_t addr, input apb_word_t want,
                              input apb_word_t mask);
        apb_word_t discard;
        apb_xfer(1'b0, addr, '0, 1'b1, want, mask, discard);
    endtask

    // STATUS as the model sees it while the transmitter stays idle
    function automatic apb_word_t status_model();
        return {27'h0, exp_frame_err, exp_overrun, 1'b0,
                exp_rx_q.size() == fifo_depth, exp_rx_q.size() != 0};
    endfunction

    task automatic check_status();
        read_check(addr_status, status_model(), 32'h1f);
    endtask

    task automatic check_data_read();
        apb_word_t want;
        want = '0;                                         // An empty FIFO reads as zero
        if (exp_rx_q.size() != 0) want = {24'h0, exp_rx_q.pop_front()};
        read_check(addr_data, want, 32'hffff_ffff);
    endtask

    // Drives a whole 8N1 frame on rx, then updates the model
    task automatic send_frame(input uart_byte_t data, input logic stop_bit);
        logic [9:0] bits;
        bits = {stop_bit, data, 1'b0}; // Start bit first, then LSB first
        @(negedge clk);
        for (int k = 0; k < 10; k++) begin
            rx = bits[k];
            repeat (clks_per_bit) @(negedge clk);
        end
        rx = 1'b1;
        repeat (2 * clks_per_bit) @(negedge clk); // Idle gap before the next frame
        if (exp_rx_en) begin
            if (!stop_bit) exp_frame_err = 1'b1;
            else if (exp_rx_q.size() < fifo_depth) exp_rx_q.push_back(data);
            else exp_overrun = 1'b1;                 // Full FIFO drops the byte
        end
    endtask

    task automatic send_glitch();
        @(negedge clk);
        rx = 1'b0;
        repeat (half_bit / 2) @(negedge clk); // Gone well before the start-bit midpoint
        rx = 1'b1;
        repeat (12 * clks_per_bit) @(negedge clk); // Room for a whole frame if one were taken
    endtask

    task automatic wait_tx_idle();
        apb_word_t st;
        int        tries;
        for (tries = 0; tries < 200; tries++) begin
            apb_xfer(1'b0, addr_status, '0, 1'b0, '0, '0, st);
            if (!st[2]) break;
        end
        if (tries == 200) begin
            tb_errors++;
            $display("Timeout: tx_busy still high after %0d STATUS reads", tries);
        end
    endtask

    task automatic push_tx(input uart_byte_t data);
        tx_push_byte = data;
        tx_push      = 1'b1;
        @(negedge clk);
        tx_push = 1'b0;
        tx_sent++;
    endtask

    task automatic wait_tx_frames();
        int cycles;
        for (cycles = 0; cycles < 20 * clks_per_bit && tx_frames != tx_sent; cycles++) begin
            @(negedge clk);
        end
        if (tx_frames != tx_sent) begin
            tb_errors++;
            $display("Timeout: %0d bytes accepted but %0d frames decoded", tx_sent, tx_frames);
        end
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        paddr = '0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        pwdata = '0;
        rx = 1'b1;       // Serial line idles high
        chk_en = 1'b0;
        chk_data = '0;
        chk_mask = '0;
        exp_slverr = 1'b0;
        tx_push = 1'b0;
        tx_push_byte = '0;
        exp_overrun = 1'b0;
        exp_frame_err = 1'b0;
        exp_rx_en = 1'b0;
        tx_sent = 0;
        tb_errors = 0;
        seed = 32'h55e2_5f38;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // CTRL readback and an offset outside the map
        apb_write(addr_ctrl, 32'h1);
        read_check(addr_ctrl, 32'h1, 32'hffff_ffff);
        apb_write(addr_ctrl, 32'h0);
        read_check(addr_ctrl, 32'h0, 32'hffff_ffff);
        read_check(4'hc, 32'h0, 32'h0); // Only pslverr matters here
        apb_write(4'hc, 32'h5a);

        // Frames with rx_en clear must leave the FIFO empty
        for (i = 0; i < 2; i++) begin
            b = uart_byte_t'($random(seed));
            send_frame(b, 1'b1);
        end
        check_status();

        apb_write(addr_ctrl, 32'h1);
        exp_rx_en = 1'b1;
        for (i = 0; i < 3; i++) begin
            n = 1 + (($random(seed) & 32'h7fff_ffff) % fifo_depth); // Burst of 1 to 4 frames
            for (j = 0; j < n; j++) begin
                b = uart_byte_t'($random(seed));
                send_frame(b, 1'b1);
            end
            while (exp_rx_q.size() != 0) begin
                check_status();     // rx_avail stays up until the last pop
                check_data_read();
            end
            check_status();
        end
        check_data_read();

        // One frame more than the FIFO holds
        for (j = 0; j < fifo_depth + 1; j++) begin
            b = uart_byte_t'($random(seed));
            send_frame(b, 1'b1);
        end
        check_status();
        while (exp_rx_q.size() != 0) check_data_read();
        apb_write(addr_status, 32'h8);
        exp_overrun = 1'b0;
        check_status();

        b = uart_byte_t'($random(seed));
        send_frame(b, 1'b0);        // Low stop bit
        check_status();
        send_glitch();
        check_status();
        apb_write(addr_status, 32'h10);
        exp_frame_err = 1'b0;
        check_status();

        // Transmit path where the second byte is followed by a write while busy
        for (i = 0; i < 4; i++) begin
            wait_tx_idle();
            b = uart_byte_t'($random(seed));
            apb_write(addr_data, {24'h0, b});
            push_tx(b);
            if (i == 1) apb_write(addr_data, {24'h0, ~b});
        end
        wait_tx_idle();
        wait_tx_frames();
        repeat (20 * clks_per_bit) @(negedge clk); // Time for a stray frame to show up
        if (tx_frames != tx_sent) begin
            tb_errors++;
            $display("tx carried %0d frames but %0d bytes were accepted", tx_frames, tx_sent);
        end

        $display("Errors: checker %0d, assertions %0d, testbench %0d",
                 chk_errors, u_uart_apb_top.u_asserts.fails, tb_errors);
        if (chk_errors + u_uart_apb_top.u_asserts.fails + tb_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- uart_apb_regs.sv
`timescale 1ns/1ps
`default_nettype none

module uart_apb_regs (
    input  logic                 clk,
    input  logic                 rst,
    input  uart_pkg::apb_addr_t  paddr,
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  uart_pkg::apb_word_t  pwdata,
    output uart_pkg::apb_word_t  prdata,
    output logic                 pready,
    output logic                 pslverr,
    output logic                 rx_en,
    output logic                 tx_start,        // One-cycle pulse to the transmitter
    output uart_pkg::uart_byte_t tx_data,
    input  logic                 tx_busy,
    input  uart_pkg::uart_byte_t fifo_rd_data,
    input  logic                 fifo_empty,
    input  logic                 fifo_full,
    output logic                 fifo_pop,
    input  logic                 overrun_pulse,
    input  logic                 frame_err_pulse
);
    import uart_pkg::*;

    logic access;     // Access phase of a transfer
    logic addr_ok;    // Offset hits one of the three registers
    logic data_wr;
    logic status_wr;
    logic ctrl_wr;
    logic overrun;    // Sticky, set by the FIFO
    logic frame_err;  // Sticky, set by the receiver

    assign access    = psel && penable;
    assign addr_ok   = paddr inside {addr_data, addr_status, addr_ctrl};
    assign data_wr   = access && pwrite && (paddr == addr_data);
    assign status_wr = access && pwrite && (paddr == addr_status);
    assign ctrl_wr   = access && pwrite && (paddr == addr_ctrl);

    assign pready  = 1'b1;               // No wait states
    assign pslverr = access && !addr_ok;
    // An empty FIFO reads as zero and is left alone
    assign fifo_pop = access && !pwrite && (paddr == addr_data) && !fifo_empty;

    always_comb begin
        prdata = '0;
        case (paddr)
            addr_data:   if (!fifo_empty) prdata = {24'h0, fifo_rd_data};
            addr_status: prdata = {27'h0, frame_err, overrun, tx_busy, fifo_full, !fifo_empty};
            addr_ctrl:   prdata = {31'h0, rx_en};
            default:     prdata = '0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rx_en     <= 1'b0;
            tx_start  <= 1'b0;
            overrun   <= 1'b0;
            frame_err <= 1'b0;
        end else begin
            tx_start <= data_wr && !tx_busy; // Writes to a busy transmitter are lost
            if (ctrl_wr) rx_en <= pwdata[0];
            // A new error wins over a clear in the same cycle
            if (overrun_pulse) begin
                overrun <= 1'b1;
            end else if (status_wr && pwdata[3]) begin
                overrun <= 1'b0;
            end
            if (frame_err_pulse) begin
                frame_err <= 1'b1;
            end else if (status_wr && pwdata[4]) begin
                frame_err <= 1'b0;
            end
        end
    end

    // Byte held for the transmitter to load along with tx_start
    always_ff @(posedge clk) begin
        if (data_wr && !tx_busy) begin
            tx_data <= pwdata[data_bits-1:0];
        end
    end

endmodule

`default_nettype wire

//--- uart_apb_top.sv
`timescale 1ns/1ps
`default_nettype none

module uart_apb_top (
    input  logic                clk,
    input  logic                rst,
    input  uart_pkg::apb_addr_t paddr,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  uart_pkg::apb_word_t pwdata,
    output uart_pkg::apb_word_t prdata,
    output logic                pready,
    output logic                pslverr,
    input  logic                rx,   // Serial in
    output logic                tx    // Serial out
);
    import uart_pkg::*;

    logic       rx_en;
    logic       tx_start;
    uart_byte_t tx_data;
    logic       tx_busy;
    uart_byte_t rx_data;
    logic       rx_valid;
    logic       rx_frame_err;
    uart_byte_t fifo_rd_data;
    logic       fifo_empty;
    logic       fifo_full;
    logic       fifo_pop;
    logic       overrun_pulse;

    uart_apb_regs u_regs (
        .clk, .rst, .paddr, .psel, .penable, .pwrite, .pwdata, .prdata, .pready, .pslverr,
        .rx_en, .tx_start, .tx_data, .tx_busy, .fifo_rd_data, .fifo_empty, .fifo_full,
        .fifo_pop, .overrun_pulse, .frame_err_pulse(rx_frame_err)
    );

    uart_rx u_rx (
        .clk, .rst, .rx_en, .rx, .rx_data, .rx_valid, .rx_frame_err
    );

    // Receiver output goes straight into the buffer, no handshake
    uart_rx_fifo u_fifo (
        .clk, .rst, .wr_en(rx_valid), .wr_data(rx_data), .pop(fifo_pop),
        .rd_data(fifo_rd_data), .empty(fifo_empty), .full(fifo_full), .overrun_pulse
    );

    uart_tx u_tx (
        .clk, .rst, .tx_start, .tx_data, .tx, .tx_busy
    );

endmodule

`default_nettype wire

//--- uart_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module uart_asserts (
    input logic clk,
    input logic rst,
    input logic pready,
    input logic tx,
    input logic tx_busy,
    input logic rx_valid,
    input logic rx_frame_err,
    input logic psel,
    input logic penable,
    input logic pslverr
);
    int fails = 0;   // Read by the testbench top for the closing count

    // No wait states on this slave
    pready_high: assert property (@(posedge clk) disable iff (rst) pready)
        else begin
            fails++;
            $error("pready went low");
        end

    // Line idles high whenever no frame is in flight
    tx_idle_high: assert property (@(posedge clk) disable iff (rst) !tx_busy |-> tx)
        else begin
            fails++;
            $error("tx low while tx_busy is low");
        end

    rx_flags_excl: assert property (@(posedge clk) disable iff (rst) !(rx_valid && rx_frame_err))
        else begin
            fails++;
            $error("rx_valid and rx_frame_err high together");
        end

    slverr_access: assert property (@(posedge clk) disable iff (rst) pslverr |-> psel && penable)
        else begin
            fails++;
            $error("pslverr high outside an access cycle");
        end

endmodule

bind uart_apb_top uart_asserts u_asserts (
    .clk, .rst, .pready, .tx, .tx_busy, .rx_valid, .rx_frame_err, .psel, .penable, .pslverr
);

`default_nettype wire

//--- uart_checker.sv
`timescale 1ns/1ps
`default_nettype none

module uart_checker (
    input  logic                 clk,
    input  logic                 rst,
    input  uart_pkg::apb_addr_t  paddr,
    input  logic                 psel,
    input  logic                 penable,
    input  uart_pkg::apb_word_t  prdata,
    input  logic                 pslverr,
    input  logic                 tx,
    input  logic                 chk_en,       // prdata is compared in this access
    input  uart_pkg::apb_word_t  chk_data,
    input  uart_pkg::apb_word_t  chk_mask,
    input  logic                 exp_slverr,
    input  logic                 tx_push,      // Byte accepted by the transmitter
    input  uart_pkg::uart_byte_t tx_push_byte,
    output int                   errors,
    output int                   frames
);
    import uart_pkg::*;

    uart_byte_t tx_q[$];       // Bytes still expected on tx, oldest first
    uart_byte_t got;
    uart_byte_t want;
    int         bit_i;
    int         apb_errors = 0;
    int         tx_errors = 0;
    int         frame_cnt = 0;

    assign errors = apb_errors + tx_errors;
    assign frames = frame_cnt;

    // APB side, sampled at the access edge
    always @(posedge clk) begin
        if (!rst && psel && penable) begin
            if (pslverr !== exp_slverr) begin
                apb_errors++;
                $display("[FAIL] pslverr at offset 0x%h: expected 0x%h got 0x%h",
                         paddr, exp_slverr, pslverr);
            end
            if (chk_en && ((prdata & chk_mask) !== (chk_data & chk_mask))) begin
                apb_errors++;
                $display("[FAIL] prdata at offset 0x%h: expected 0x%h got 0x%h",
                         paddr, chk_data & chk_mask, prdata & chk_mask);
            end
        end
        if (!rst && tx_push) tx_q.push_back(tx_push_byte);
    end

    // Serial decoder, each bit is sampled at its midpoint
    always begin
        @(negedge tx);
        repeat (half_bit) @(posedge clk);
        if (tx !== 1'b0) begin
            tx_errors++;
            $display("tx start bit did not stay low until its midpoint");
        end else begin
            for (bit_i = 0; bit_i < data_bits; bit_i++) begin
                repeat (clks_per_bit) @(posedge clk);
                got[bit_i] = tx;            // LSB arrives first
            end
            repeat (clks_per_bit) @(posedge clk);
            if (tx !== 1'b1) begin
                tx_errors++;
                $display("[FAIL] tx stop bit: expected 0x1 got 0x%h", tx);
            end
            frame_cnt++;
            if (tx_q.size() == 0) begin
                tx_errors++;
                $display("tx sent byte 0x%h although no DATA write was pending", got);
            end else begin
                want = tx_q.pop_front();
                if (got !== want) begin
                    tx_errors++;
                    $display("[FAIL] tx byte: expected 0x%h got 0x%h", want, got);
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- uart_pkg.sv
`default_nettype none

package uart_pkg;

    // Serial timing, kept small so a frame takes only 160 clocks in simulation
    localparam int clks_per_bit = 16;           // A real build changes only this divisor
    localparam int half_bit     = clks_per_bit / 2; // Falling edge to start-bit midpoint
    localparam int data_bits    = 8;            // 8N1 framing, no parity
    localparam int fifo_depth   = 4;            // Receive buffer entries

    typedef logic [7:0]  uart_byte_t;  // One character
    typedef logic [3:0]  apb_addr_t;   // Register byte offset
    typedef logic [31:0] apb_word_t;   // APB read and write data
    typedef logic [3:0]  bit_cnt_t;    // Data bit index within a frame
    typedef logic [4:0]  baud_cnt_t;   // Clock count within one bit

    // Register map
    // DATA   read pops the receive FIFO, write starts a transmission
    // STATUS bit 0 rx_avail, bit 1 rx_full, bit 2 tx_busy, bit 3 overrun, bit 4 frame_err
    //        Writing a one to bit 3 or bit 4 clears that sticky flag
    // CTRL   bit 0 rx_en
    localparam apb_addr_t addr_data   = 4'h0;
    localparam apb_addr_t addr_status = 4'h4;
    localparam apb_addr_t addr_ctrl   = 4'h8;

    // Receiver FSM
    typedef enum logic [1:0] {
        rx_st_idle,   // Waiting for the line to drop
        rx_st_start,  // Counting to the start-bit midpoint
        rx_st_data,   // Sampling data bits mid-bit
        rx_st_stop    // Waiting for the stop-bit midpoint
    } rx_state_t;

    // Transmitter FSM
    typedef enum logic [1:0] {
        tx_st_idle,
        tx_st_start,
        tx_st_data,
        tx_st_stop
    } tx_state_t;

endpackage

`default_nettype wire

//--- uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rx_en,        // Only checked between frames
    input  logic                 rx,           // Asynchronous serial line, idle high
    output uart_pkg::uart_byte_t rx_data,      // Valid while rx_valid is high
    output logic                 rx_valid,     // One-cycle pulse per good frame
    output logic                 rx_frame_err  // One-cycle pulse when the stop bit is low
);
    import uart_pkg::*;

    logic      rx_meta;   // First synchronizer stage
    logic      rx_sync;   // Second stage, the only copy of the line the FSM looks at
    rx_state_t state;
    baud_cnt_t baud_cnt;
    bit_cnt_t  bit_idx;
    logic      bit_done;  // Last clock of a full bit period

    assign bit_done = (baud_cnt == baud_cnt_t'(clks_per_bit - 1));

    // Both stages come out of reset at the idle level, so reset never looks like a start bit
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= rx_st_idle;
            baud_cnt     <= '0;
            bit_idx      <= '0;
            rx_valid     <= 1'b0;
            rx_frame_err <= 1'b0;
        end else begin
            rx_valid     <= 1'b0; // Both flags are single-cycle pulses
            rx_frame_err <= 1'b0;
            case (state)
                rx_st_idle: begin
                    baud_cnt <= '0;
                    bit_idx  <= '0;
                    if (rx_en && !rx_sync) begin
                        state <= rx_st_start; // Line dropped, go look at its middle
                    end
                end
                rx_st_start: begin
                    if (baud_cnt == baud_cnt_t'(half_bit - 1)) begin
                        baud_cnt <= '0;
                        // A line that is high again at the midpoint was only a glitch
                        state    <= rx_sync ? rx_st_idle : rx_st_data;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                rx_st_data: begin
                    if (bit_done) begin
                        baud_cnt <= '0;
                        if (bit_idx == bit_cnt_t'(data_bits - 1)) begin
                            state <= rx_st_stop;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                rx_st_stop: begin
                    if (bit_done) begin // Midpoint of the stop bit
                        state        <= rx_st_idle;
                        rx_valid     <= rx_sync;
                        rx_frame_err <= !rx_sync;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                default: state <= rx_st_idle;
            endcase
        end
    end

    // Data arrives LSB first, so each new bit enters at the top and moves down
    always_ff @(posedge clk) begin
        if (state == rx_st_data && bit_done) begin
            rx_data <= {rx_sync, rx_data[data_bits-1:1]};
        end
    end

endmodule

`default_nettype wire

//--- uart_rx_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx_fifo (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 wr_en,         // Byte from the receiver
    input  uart_pkg::uart_byte_t wr_data,
    input  logic                 pop,           // Head consumed by a DATA read
    output uart_pkg::uart_byte_t rd_data,       // Current head, meaningless when empty
    output logic                 empty,
    output logic                 full,
    output logic                 overrun_pulse  // A byte arrived with no room for it
);
    import uart_pkg::*;

    // Depth is a power of two, so the pointers wrap on their own
    typedef logic [$clog2(fifo_depth)-1:0]   ptr_t;
    typedef logic [$clog2(fifo_depth+1)-1:0] cnt_t;

    uart_byte_t mem [fifo_depth];
    ptr_t       wr_ptr;
    ptr_t       rd_ptr;
    cnt_t       count;   // Entries held, 0 to fifo_depth
    logic       do_wr;
    logic       do_rd;

    assign empty   = (count == '0);
    assign full    = (count == cnt_t'(fifo_depth));
    assign do_wr   = wr_en && !full; // A full buffer drops the new byte
    assign do_rd   = pop && !empty;
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            overrun_pulse <= 1'b0;
        end else begin
            overrun_pulse <= wr_en && full;
            if (do_wr) wr_ptr <= wr_ptr + 1'b1;
            if (do_rd) rd_ptr <= rd_ptr + 1'b1;
            // Simultaneous write and pop leave the count unchanged
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 tx_start,  // Ignored unless the transmitter is idle
    input  uart_pkg::uart_byte_t tx_data,
    output logic                 tx,        // Registered line output
    output logic                 tx_busy
);
    import uart_pkg::*;

    tx_state_t  state;
    baud_cnt_t  baud_cnt;
    bit_cnt_t   bit_idx;
    uart_byte_t shift_reg;  // Bits still to be sent, LSB next
    logic       bit_done;
    logic       load;       // Byte accepted this cycle
    logic       shift_en;   // Next data bit moves onto the line

    assign bit_done = (baud_cnt == baud_cnt_t'(clks_per_bit - 1));
    assign load     = (state == tx_st_idle) && tx_start;
    assign shift_en = bit_done && (state == tx_st_start || state == tx_st_data);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= tx_st_idle;
            baud_cnt <= '0;
            bit_idx  <= '0;
            tx       <= 1'b1; // Line idles high
            tx_busy  <= 1'b0;
        end else if (load) begin
            state    <= tx_st_start;
            baud_cnt <= '0;
            bit_idx  <= '0;
            tx       <= 1'b0; // Start bit goes out on the edge after tx_start
            tx_busy  <= 1'b1;
        end else if (state != tx_st_idle) begin
            baud_cnt <= bit_done ? '0 : baud_cnt + 1'b1;
            if (bit_done) begin
                case (state)
                    tx_st_start: begin
                        state <= tx_st_data;
                        tx    <= shift_reg[0];
                    end
                    tx_st_data: begin
                        if (bit_idx == bit_cnt_t'(data_bits - 1)) begin
                            state <= tx_st_stop;
                            tx    <= 1'b1; // Stop bit
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                            tx      <= shift_reg[0];
                        end
                    end
                    default: begin // End of the stop bit, 160 clocks after the start
                        state   <= tx_st_idle;
                        tx_busy <= 1'b0;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            shift_reg <= tx_data;
        end else if (shift_en) begin
            shift_reg <= {1'b0, shift_reg[data_bits-1:1]}; // Drop the bit now on the line
        end
    end

endmodule

`default_nettype wire
